/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_mem_controller
FILELIST  := src.f
BUILD     := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

/* src.f */
+incdir+verilog
verilog/mc_core_pkg.sv
verilog/mc_cache_pkg.sv
verilog/mem_request_decode.sv
verilog/mem_access_sequencer.sv
verilog/mem_load_assemble.sv
verilog/mem_controller.sv
verification/mc_clock_gen.sv
verification/tb_mem_controller.sv

/* verification/mc_clock_gen.sv */
// Testbench clock and reset; 10 ns period, reset high for the first 16 rising edges.
`timescale 1ns/1ps

module mc_clock_gen (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0; // released on an edge like the other inputs
    end

endmodule

/* verification/tb_mem_controller.sv */
// Directed tests of the memory controller against a byte-addressed cache model.
// The model holds 4 KB only, so every test address stays below 4096.
`timescale 1ns/1ps
`include "mc_defines.svh"

module tb_mem_controller;
    import mc_core_pkg::*;
    import mc_cache_pkg::*;

    localparam int MEM_BYTES = 4096;
    localparam int N_TESTS = 6;
    localparam int MAX_DELAY = 3;
    // up to three requests per test, each access ISSUE, answer and STEP
    localparam int TIMEOUT = 16 + N_TESTS * 3 * `MC_MAX_ELEMS * (MAX_DELAY + 4) + 200;

    logic                     clk;
    logic                     reset;
    logic                     req_valid;
    mem_op_t                  req_op;
    logic                     req_vector;
    elem_size_t               req_size;
    logic [`MC_ADDR_W-1:0]    req_addr;
    logic [`MC_LEN_W-1:0]     req_length;
    logic                     req_vm;
    logic [`MC_MAX_ELEMS-1:0] req_mask;
    logic [`MC_SCALAR_W-1:0]  req_scalar_wdata;
    logic [`MC_VREG_W-1:0]    req_vector_wdata;
    logic                     req_ready;
    logic                     done;
    logic [`MC_SCALAR_W-1:0]  load_scalar;
    logic [`MC_VREG_W-1:0]    load_vector;
    cache_cmd_t               cache_cmd;
    logic [`MC_ADDR_W-1:0]    cache_addr;
    elem_size_t               cache_size;
    logic [`MC_WORD_W-1:0]    cache_wdata;
    logic                     cache_done = 1'b0;
    logic [`MC_WORD_W-1:0]    cache_rdata = '0;

    logic [7:0]  mem [MEM_BYTES];     // cache model storage
    logic [7:0]  ref_mem [MEM_BYTES]; // expected contents
    logic [31:0] rand_state = 32'h8fb5_10fe;
    logic        pending;
    int          delay_left;
    int          access_count;
    int          err_count = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;

    mc_clock_gen u_clk (.clk(clk), .reset(reset));

    mem_controller u_dut (.*);

    function automatic logic [7:0] fill_byte(int a);
        return 8'(a) ^ {a[11:8], a[11:8]} ^ 8'h3c;
    endfunction

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic int rand_delay();
        logic [31:0] r;
        r = next_rand();
        return int'(r[17:16]); // 0 to MAX_DELAY
    endfunction

    function automatic int size_bytes(elem_size_t s);
        case (s)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;
        endcase
    endfunction

    function automatic logic [31:0] ref_word(int a);
        return {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
    endfunction

    function automatic int count_active(int len, logic vm, logic [7:0] mask);
        int n;
        n = 0;
        for (int i = 0; i < len; i++)
            if (vm || mask[i]) n++;
        return n;
    endfunction

    // element i at base + i * size, inactive slots zero
    function automatic logic [`MC_VREG_W-1:0] expect_vector(elem_size_t s, int a, int len,
            logic vm, logic [7:0] mask);
        logic [`MC_VREG_W-1:0] v;
        logic [31:0]           w;
        int                    nb;
        v = '0;
        nb = size_bytes(s);
        for (int i = 0; i < len; i++) begin
            if (vm || mask[i]) begin
                w = ref_word(a + i * nb);
                for (int b = 0; b < nb; b++)
                    v[(i * nb + b) * 8 +: 8] = w[b * 8 +: 8];
            end
        end
        return v;
    endfunction

    task automatic ref_write(input int a, input logic [31:0] data, input int nb);
        for (int b = 0; b < nb; b++)
            ref_mem[a + b] = data[b * 8 +: 8];
    endtask

    task automatic store_expect(input elem_size_t s, input int a, input int len, input logic vm,
            input logic [7:0] mask, input logic [`MC_VREG_W-1:0] vdata);
        int nb;
        nb = size_bytes(s);
        for (int i = 0; i < len; i++)
            if (vm || mask[i]) ref_write(a + i * nb, vdata[i * nb * 8 +: 32], nb);
    endtask

    task automatic check_equal(input string name, input logic [`MC_VREG_W-1:0] got,
            input logic [`MC_VREG_W-1:0] exp);
        assert (got === exp) else begin
            $display("** Error @%0t: %s = %0h, expected %0h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic compare_memory();
        for (int a = 0; a < MEM_BYTES; a++)
            check_equal($sformatf("mem[%0h]", a), mem[a], ref_mem[a]);
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, err_count - errs_before);
            tests_failed++;
        end
    endtask

    // one request from valid to done
    task automatic run_request(input mem_op_t op, input logic vec, input elem_size_t s,
            input int a, input int len, input logic vm, input logic [7:0] mask,
            input logic [`MC_SCALAR_W-1:0] sdata, input logic [`MC_VREG_W-1:0] vdata);
        @(posedge clk);
        req_valid        <= 1'b1;
        req_op           <= op;
        req_vector       <= vec;
        req_size         <= s;
        req_addr         <= `MC_ADDR_W'(a);
        req_length       <= `MC_LEN_W'(len);
        req_vm           <= vm;
        req_mask         <= mask;
        req_scalar_wdata <= sdata;
        req_vector_wdata <= vdata;
        do @(posedge clk); while (!req_ready);
        req_valid <= 1'b0;
        do @(posedge clk); while (!done);
    endtask

    task automatic test_reset_state();
        int e0;
        e0 = err_count;
        check_equal("req_ready", req_ready, 1'b1);
        check_equal("cache_cmd", cache_cmd, CMD_NOP);
        check_equal("done", done, 1'b0);
        end_test("reset state", e0);
    endtask

    task automatic test_scalar_loads();
        int          e0;
        int          a;
        logic [31:0] w;
        e0 = err_count;
        a = 'h100;
        w = ref_word(a);
        while (!w[31]) begin // need a negative word
            a += 4;
            w = ref_word(a);
        end
        run_request(OP_LOAD, 1'b0, SIZE_WORD, a, 1, 1'b0, '0, '0, '0);
        check_equal("load_scalar", load_scalar, {{32{w[31]}}, w});
        run_request(OP_LOAD, 1'b0, SIZE_DWORD, 'h200, 1, 1'b0, '0, '0, '0);
        check_equal("load_scalar", load_scalar, {ref_word('h204), ref_word('h200)});
        end_test("scalar loads", e0);
    endtask

    task automatic test_scalar_stores();
        int e0;
        e0 = err_count;
        run_request(OP_STORE, 1'b0, SIZE_DWORD, 'h300, 1, 1'b0, '0,
                    64'h0123_4567_89ab_cdef, '0);
        ref_write('h300, 32'h89ab_cdef, 4);
        ref_write('h304, 32'h0123_4567, 4);
        run_request(OP_STORE, 1'b0, SIZE_WORD, 'h30c, 1, 1'b0, '0, 64'hffff_ffff_5a5a_a5a5, '0);
        ref_write('h30c, 32'h5a5a_a5a5, 4);
        compare_memory();
        end_test("scalar stores", e0);
    endtask

    task automatic test_vector_loads();
        int         e0;
        int         n0;
        int         a;
        elem_size_t s;
        e0 = err_count;
        for (int k = 0; k < 3; k++) begin
            s = elem_size_t'(k);
            a = 'h400 + k * 'h40;
            n0 = access_count;
            // bit 7 lies beyond the length
            run_request(OP_LOAD, 1'b1, s, a, 7, 1'b0, 8'b1011_0101, '0, '0);
            check_equal("load_vector", load_vector, expect_vector(s, a, 7, 1'b0, 8'b1011_0101));
            check_equal("cache commands", access_count - n0, count_active(7, 1'b0, 8'b1011_0101));
        end
        end_test("vector loads", e0);
    endtask

    task automatic test_vector_store_vm();
        int                    e0;
        int                    n0;
        logic [`MC_VREG_W-1:0] vdata;
        e0 = err_count;
        for (int i = 0; i < 8; i++)
            vdata[i * 32 +: 32] = next_rand();
        n0 = access_count;
        run_request(OP_STORE, 1'b1, SIZE_WORD, 'h500, 5, 1'b1, 8'h00, '0, vdata);
        store_expect(SIZE_WORD, 'h500, 5, 1'b1, 8'h00, vdata);
        check_equal("cache commands", access_count - n0, 5);
        compare_memory();
        end_test("vector store vm", e0);
    endtask

    task automatic test_delay_roundtrip();
        int                    e0;
        logic [`MC_VREG_W-1:0] vdata;
        e0 = err_count;
        for (int i = 0; i < 8; i++)
            vdata[i * 32 +: 32] = next_rand();
        run_request(OP_STORE, 1'b1, SIZE_HALF, 'h600, 8, 1'b1, '0, '0, vdata);
        store_expect(SIZE_HALF, 'h600, 8, 1'b1, '0, vdata);
        run_request(OP_LOAD, 1'b1, SIZE_HALF, 'h600, 8, 1'b1, '0, '0, '0);
        check_equal("load_vector", load_vector, {128'b0, vdata[127:0]});
        compare_memory();
        end_test("random delay roundtrip", e0);
    endtask

    // cache model, answers 1 + 0..3 cycles after a command appears
    always @(posedge clk) begin
        if (reset) begin
            cache_done <= 1'b0;
            cache_rdata <= '0;
            pending = 1'b0;
            access_count = 0;
            for (int a = 0; a < MEM_BYTES; a++)
                mem[a] = fill_byte(a);
        end else if (cache_done) begin
            cache_done <= 1'b0;
        end else if (cache_cmd != CMD_NOP) begin
            if (!pending) begin
                pending = 1'b1;
                delay_left = rand_delay();
            end
            if (delay_left > 0) begin
                delay_left--;
            end else begin
                pending = 1'b0;
                access_count++;
                cache_done <= 1'b1;
                assert (int'(cache_addr) <= MEM_BYTES - 4) else begin
                    $display("cache access at %0t outside the model, address %0h", $time,
                             cache_addr);
                    err_count++;
                end
                if (cache_cmd == CMD_STORE) begin
                    for (int b = 0; b < size_bytes(cache_size); b++)
                        mem[int'(cache_addr) + b] = cache_wdata[b * 8 +: 8];
                end else begin
                    cache_rdata <= {mem[int'(cache_addr) + 3], mem[int'(cache_addr) + 2],
                                    mem[int'(cache_addr) + 1], mem[int'(cache_addr)]};
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT) begin
            $display("timeout, tests not finished after %0d cycles", TIMEOUT);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        req_valid = 1'b0;
        req_op = OP_LOAD;
        req_vector = 1'b0;
        req_size = SIZE_WORD;
        req_addr = '0;
        req_length = '0;
        req_vm = 1'b0;
        req_mask = '0;
        req_scalar_wdata = '0;
        req_vector_wdata = '0;
        for (int a = 0; a < MEM_BYTES; a++)
            ref_mem[a] = fill_byte(a);
        do @(posedge clk); while (reset);
        test_reset_state();
        test_scalar_loads();
        test_scalar_stores();
        test_vector_loads();
        test_vector_store_vm();
        test_delay_roundtrip();
        $display("%0d tests, %0d failed, %0d check errors", N_TESTS, tests_failed, err_count);
        if (err_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* verilog/mc_cache_pkg.sv */
// Cache-side command encoding and sequencer states.
package mc_cache_pkg;

    typedef enum logic [1:0] {
        CMD_NOP   = 2'd0,
        CMD_LOAD  = 2'd1,
        CMD_STORE = 2'd2
    } cache_cmd_t;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ISSUE = 2'd1, // first cycle of an element or beat
        ST_WAIT  = 2'd2, // command held for cache_done
        ST_STEP  = 2'd3
    } seq_state_t;

endpackage

/* verilog/mc_core_pkg.sv */
// Core-side request encodings.
// DWORD is legal for scalar requests only.
package mc_core_pkg;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mem_op_t;

    // element or scalar size, 1, 2, 4 or 8 bytes
    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_HALF  = 2'd1,
        SIZE_WORD  = 2'd2,
        SIZE_DWORD = 2'd3
    } elem_size_t;

endpackage

/* verilog/mc_defines.svh */
// Widths and limits of the memory controller.
// MC_LEN_W must hold MC_MAX_ELEMS itself, not only the largest index.
`ifndef MC_DEFINES_SVH
`define MC_DEFINES_SVH

// byte address into the data cache
`define MC_ADDR_W 20

// one cache access moves one word
`define MC_WORD_W 32

// core scalar register, a double-word is two cache words
`define MC_SCALAR_W 64

// core vector register
`define MC_VREG_W 256

`define MC_MAX_ELEMS 8 // largest vector length
`define MC_LEN_W 4     // element count, 0 to MC_MAX_ELEMS

`endif

/* verilog/mem_access_sequencer.sv */
// Walks the latched request one cache word at a time; inputs must hold while busy.
// A masked-off element costs one ISSUE cycle and no cache access.
`timescale 1ns/1ps
`include "mc_defines.svh"

module mem_access_sequencer #(
    parameter int IDX_W = $clog2(`MC_MAX_ELEMS)
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  mc_core_pkg::mem_op_t        op,
    input  logic                        vector,
    input  mc_core_pkg::elem_size_t     size,
    input  logic [`MC_ADDR_W-1:0]       base_addr,
    input  logic [`MC_LEN_W-1:0]        elem_count,
    input  logic [`MC_MAX_ELEMS-1:0]    active_mask,
    input  logic [`MC_SCALAR_W-1:0]     scalar_wdata,
    input  logic [`MC_VREG_W-1:0]       vector_wdata,
    input  logic                        cache_done,
    output mc_cache_pkg::cache_cmd_t    cache_cmd,
    output logic [`MC_ADDR_W-1:0]       cache_addr,
    output mc_core_pkg::elem_size_t     cache_size,
    output logic [`MC_WORD_W-1:0]       cache_wdata,
    output logic                        capture,
    output logic [IDX_W-1:0]            cap_index,
    output logic                        cap_beat,
    output logic                        seq_idle,
    output logic                        done
);
    import mc_core_pkg::*;
    import mc_cache_pkg::*;

    seq_state_t             state;
    logic [`MC_LEN_W-1:0]   elem_idx;
    logic                   beat;      // high word of a double-word
    logic [`MC_ADDR_W-1:0]  elem_addr;
    logic [`MC_ADDR_W-1:0]  stride;
    logic [IDX_W-1:0]       idx;
    logic                   elem_active;
    logic                   last_elem;
    logic                   is_dword;
    logic                   busy;

    assign idx         = elem_idx[IDX_W-1:0];
    assign elem_active = active_mask[idx];
    assign last_elem   = (elem_idx + 1'b1) == elem_count;
    assign is_dword    = !vector && size == SIZE_DWORD;
    assign busy        = state == ST_ISSUE || state == ST_WAIT;

    always_comb begin
        case (size)
            SIZE_BYTE: stride = `MC_ADDR_W'(1);
            SIZE_HALF: stride = `MC_ADDR_W'(2);
            default:   stride = `MC_ADDR_W'(4);
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            elem_idx <= '0;
            beat     <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: if (start) begin
                    state     <= ST_ISSUE;
                    elem_idx  <= '0;
                    beat      <= 1'b0;
                    elem_addr <= base_addr;
                end
                ST_ISSUE: if (!elem_active) begin
                    if (last_elem) begin
                        state <= ST_IDLE;
                    end else begin
                        elem_idx  <= elem_idx + 1'b1;
                        elem_addr <= elem_addr + stride;
                    end
                end else begin
                    state <= cache_done ? ST_STEP : ST_WAIT;
                end
                ST_WAIT: if (cache_done) state <= ST_STEP;
                default: begin
                    state <= ST_ISSUE;
                    if (is_dword && !beat) begin
                        beat <= 1'b1;
                    end else if (last_elem) begin
                        state <= ST_IDLE;
                    end else begin
                        elem_idx  <= elem_idx + 1'b1;
                        elem_addr <= elem_addr + stride;
                    end
                end
            endcase
        end
    end

    assign cache_cmd  = !(busy && elem_active) ? CMD_NOP :
                        (op == OP_STORE) ? CMD_STORE : CMD_LOAD;
    assign cache_addr = beat ? elem_addr + `MC_ADDR_W'(4) : elem_addr;
    assign cache_size = vector ? size : SIZE_WORD;

    always_comb begin
        if (!vector) begin
            cache_wdata = beat ? scalar_wdata[`MC_SCALAR_W-1:`MC_WORD_W]
                               : scalar_wdata[`MC_WORD_W-1:0];
        end else begin
            case (size)
                SIZE_BYTE: cache_wdata = {24'b0, vector_wdata[idx*8 +: 8]};
                SIZE_HALF: cache_wdata = {16'b0, vector_wdata[idx*16 +: 16]};
                default:   cache_wdata = vector_wdata[idx*32 +: 32];
            endcase
        end
    end

    assign capture   = busy && elem_active && cache_done && op == OP_LOAD;
    assign cap_index = idx;
    assign cap_beat  = beat;
    assign seq_idle  = state == ST_IDLE;
    // last word already captured when STEP or a skip ends the walk
    assign done = (state == ST_STEP && last_elem && !(is_dword && !beat))
               || (state == ST_ISSUE && !elem_active && last_elem);

    a_cmd_held: assert property (@(posedge clk) disable iff (reset)
        cache_cmd != CMD_NOP && !cache_done |=> $stable(cache_cmd)
            && $stable(cache_addr) && $stable(cache_wdata));

    // done is a single pulse that ends in IDLE
    a_done_to_idle: assert property (@(posedge clk) disable iff (reset)
        done |=> state == ST_IDLE);

endmodule

/* verilog/mem_controller.sv */
// Memory access controller between the core and a word-wide data cache.
// One request in flight; load results hold until the next request starts.
`timescale 1ns/1ps
`include "mc_defines.svh"

module mem_controller (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        req_valid,
    input  mc_core_pkg::mem_op_t        req_op,
    input  logic                        req_vector,
    input  mc_core_pkg::elem_size_t     req_size,
    input  logic [`MC_ADDR_W-1:0]       req_addr,
    input  logic [`MC_LEN_W-1:0]        req_length,
    input  logic                        req_vm,
    input  logic [`MC_MAX_ELEMS-1:0]    req_mask,
    input  logic [`MC_SCALAR_W-1:0]     req_scalar_wdata,
    input  logic [`MC_VREG_W-1:0]       req_vector_wdata,
    output logic                        req_ready,
    output logic                        done,
    output logic [`MC_SCALAR_W-1:0]     load_scalar,
    output logic [`MC_VREG_W-1:0]       load_vector,
    output mc_cache_pkg::cache_cmd_t    cache_cmd,
    output logic [`MC_ADDR_W-1:0]       cache_addr,
    output mc_core_pkg::elem_size_t     cache_size,
    output logic [`MC_WORD_W-1:0]       cache_wdata,
    input  logic                        cache_done,
    input  logic [`MC_WORD_W-1:0]       cache_rdata
);
    localparam int IDX_W = $clog2(`MC_MAX_ELEMS);

    logic                       start;
    mc_core_pkg::mem_op_t       op;
    logic                       vector;
    mc_core_pkg::elem_size_t    size;
    logic [`MC_ADDR_W-1:0]      base_addr;
    logic [`MC_LEN_W-1:0]       elem_count;
    logic [`MC_MAX_ELEMS-1:0]   active_mask;
    logic [`MC_SCALAR_W-1:0]    scalar_wdata;
    logic [`MC_VREG_W-1:0]      vector_wdata;
    logic                       seq_idle;
    logic                       capture;
    logic [IDX_W-1:0]           cap_index;
    logic                       cap_beat;

    mem_request_decode u_decode (
        .clk, .reset, .req_valid, .req_op, .req_vector, .req_size, .req_addr,
        .req_length, .req_vm, .req_mask, .req_scalar_wdata, .req_vector_wdata,
        .seq_idle, .req_ready, .start, .op, .vector, .size, .base_addr,
        .elem_count, .active_mask, .scalar_wdata, .vector_wdata
    );

    mem_access_sequencer #(.IDX_W(IDX_W)) u_seq (
        .clk, .reset, .start, .op, .vector, .size, .base_addr, .elem_count,
        .active_mask, .scalar_wdata, .vector_wdata, .cache_done, .cache_cmd,
        .cache_addr, .cache_size, .cache_wdata, .capture, .cap_index, .cap_beat,
        .seq_idle, .done
    );

    mem_load_assemble #(.IDX_W(IDX_W)) u_assemble (
        .clk, .reset, .start, .vector, .size, .capture, .cap_index, .cap_beat,
        .cache_rdata, .load_scalar, .load_vector
    );

endmodule

/* verilog/mem_load_assemble.sv */
// Builds the load result from captured cache words; cleared on every start.
// vector and size come from the latched request and hold while it runs.
`timescale 1ns/1ps
`include "mc_defines.svh"

module mem_load_assemble #(
    parameter int IDX_W = $clog2(`MC_MAX_ELEMS)
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  logic                        vector,
    input  mc_core_pkg::elem_size_t     size,
    input  logic                        capture,
    input  logic [IDX_W-1:0]            cap_index,
    input  logic                        cap_beat,
    input  logic [`MC_WORD_W-1:0]       cache_rdata,
    output logic [`MC_SCALAR_W-1:0]     load_scalar,
    output logic [`MC_VREG_W-1:0]       load_vector
);
    import mc_core_pkg::*;

    always_ff @(posedge clk) begin
        if (reset || start) begin
            // skipped elements stay zero
            load_scalar <= '0;
            load_vector <= '0;
        end else if (capture) begin
            if (vector) begin
                case (size)
                    SIZE_BYTE: load_vector[cap_index*8 +: 8]   <= cache_rdata[7:0];
                    SIZE_HALF: load_vector[cap_index*16 +: 16] <= cache_rdata[15:0];
                    default:   load_vector[cap_index*32 +: 32] <= cache_rdata;
                endcase
            end else if (size == SIZE_DWORD) begin
                if (cap_beat)
                    load_scalar[`MC_SCALAR_W-1:`MC_WORD_W] <= cache_rdata;
                else
                    load_scalar[`MC_WORD_W-1:0] <= cache_rdata;
            end else begin
                // word load, sign-extended
                load_scalar <= {{(`MC_SCALAR_W-`MC_WORD_W){cache_rdata[`MC_WORD_W-1]}},
                                cache_rdata};
            end
        end
    end

endmodule

/* verilog/mem_request_decode.sv */
// Takes one core request at a time; the latched plan is stable until the next accept.
// Scalar requests must be WORD or DWORD, vector requests BYTE, HALF or WORD.
`timescale 1ns/1ps
`include "mc_defines.svh"

module mem_request_decode (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        req_valid,
    input  mc_core_pkg::mem_op_t        req_op,
    input  logic                        req_vector,
    input  mc_core_pkg::elem_size_t     req_size,
    input  logic [`MC_ADDR_W-1:0]       req_addr,
    input  logic [`MC_LEN_W-1:0]        req_length,
    input  logic                        req_vm,
    input  logic [`MC_MAX_ELEMS-1:0]    req_mask,
    input  logic [`MC_SCALAR_W-1:0]     req_scalar_wdata,
    input  logic [`MC_VREG_W-1:0]       req_vector_wdata,
    input  logic                        seq_idle,
    output logic                        req_ready,
    output logic                        start,
    output mc_core_pkg::mem_op_t        op,
    output logic                        vector,
    output mc_core_pkg::elem_size_t     size,
    output logic [`MC_ADDR_W-1:0]       base_addr,
    output logic [`MC_LEN_W-1:0]        elem_count,
    output logic [`MC_MAX_ELEMS-1:0]    active_mask,
    output logic [`MC_SCALAR_W-1:0]     scalar_wdata,
    output logic [`MC_VREG_W-1:0]       vector_wdata
);
    import mc_core_pkg::*;

    logic                     accept;
    logic [`MC_MAX_ELEMS-1:0] mask_next;

    // sequencer still reports idle during the start cycle
    assign req_ready = seq_idle & ~start;
    assign accept    = req_valid & req_ready;

    // vm overrides the mask, the length bounds both
    always_comb begin
        for (int i = 0; i < `MC_MAX_ELEMS; i++) begin
            if (req_vector)
                mask_next[i] = (req_vm | req_mask[i]) & (i < req_length);
            else
                mask_next[i] = (i == 0); // scalar is one element
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            start <= 1'b0;
        else
            start <= accept;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op           <= req_op;
            vector       <= req_vector;
            size         <= req_size;
            base_addr    <= req_addr;
            elem_count   <= req_vector ? req_length : {{(`MC_LEN_W-1){1'b0}}, 1'b1};
            active_mask  <= mask_next;
            scalar_wdata <= req_scalar_wdata;
            vector_wdata <= req_vector_wdata;
        end
    end

    a_scalar_size: assert property (@(posedge clk) disable iff (reset)
        accept && !req_vector |-> req_size inside {SIZE_WORD, SIZE_DWORD});

    // no vector double-words, length within the register
    a_vector_req: assert property (@(posedge clk) disable iff (reset)
        accept && req_vector |-> req_size != SIZE_DWORD && req_length != 0
            && req_length <= `MC_MAX_ELEMS);

endmodule
